//--- source/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// link count, order xpos ypos zpos xneg yneg zneg
`define ROUTER_PORTS 6

// entries per input queue
`define QUEUE_DEPTH 16

// field widths of one flit
`define COORD_WIDTH 3
`define PAYLOAD_WIDTH 32
`define TAG_WIDTH 8

`endif

//--- source/router_pkg.sv
`include "router_config.svh"

package router_pkg;

    typedef logic [`COORD_WIDTH-1:0] coord_t;
    typedef logic [`PAYLOAD_WIDTH-1:0] payload_t;
    typedef logic [`TAG_WIDTH-1:0] tag_t;
    typedef logic [2:0] port_t;

    typedef struct packed {
        coord_t z;
        coord_t y;
        coord_t x;
    } dest_t;

    typedef struct packed {
        dest_t dest;
        tag_t tag;
        payload_t payload;
    } flit_t;

    // link routes share the link index
    typedef enum logic [2:0] {
        route_xpos = 3'd0,
        route_ypos = 3'd1,
        route_zpos = 3'd2,
        route_xneg = 3'd3,
        route_yneg = 3'd4,
        route_zneg = 3'd5,
        route_local = 3'd6
    } route_t;

    // dimension order x, y, z; shorter way round the ring, ties go positive
    function automatic route_t route_of(input dest_t dest, input coord_t own_x,
                                        input coord_t own_y, input coord_t own_z);
        coord_t dx;
        coord_t dy;
        coord_t dz;
        dx = dest.x - own_x;
        dy = dest.y - own_y;
        dz = dest.z - own_z;
        if (dx != '0) begin
            return (dx <= 3'd4) ? route_xpos : route_xneg;
        end
        if (dy != '0) begin
            return (dy <= 3'd4) ? route_ypos : route_yneg;
        end
        if (dz != '0) begin
            return (dz <= 3'd4) ? route_zpos : route_zneg;
        end
        return route_local;
    endfunction

endpackage

//--- source/switch_req_if.sv
`timescale 1ns/100ps
`include "router_config.svh"

interface switch_req_if import router_pkg::*; ();

    // one request slot per input queue head
    logic req_valid [`ROUTER_PORTS];
    flit_t req_flit [`ROUTER_PORTS];
    route_t req_route [`ROUTER_PORTS];

    // grant pops the head at the same edge
    logic grant [`ROUTER_PORTS];

    modport requester (
        output req_valid, req_flit, req_route,
        input grant
    );

    modport arbiter (
        input req_valid, req_flit, req_route,
        output grant
    );

endinterface

//--- source/flit_queue.sv
`timescale 1ns/100ps
`include "router_config.svh"

module flit_queue import router_pkg::*; (
    input logic clk,
    input logic reset,
    input flit_t wr_flit,
    input logic wr_en,
    input logic rd_en,
    output flit_t head,
    output logic not_empty
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    flit_t mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic full;

    assign full = (count == CNT_W'(`QUEUE_DEPTH));
    assign not_empty = (count != '0);
    // first word fall through
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no back-pressure on the links, so the sender must pace itself
    assert property (@(posedge clk) disable iff (reset) !(wr_en && !rd_en && full));
    assert property (@(posedge clk) disable iff (reset) rd_en |-> not_empty);

endmodule

//--- source/input_unit.sv
`timescale 1ns/100ps
`include "router_config.svh"

module input_unit import router_pkg::*; #(
    parameter coord_t cur_x = '0,
    parameter coord_t cur_y = '0,
    parameter coord_t cur_z = '0
) (
    input logic clk,
    input logic reset,
    input flit_t in_flit [`ROUTER_PORTS],
    input logic in_valid [`ROUTER_PORTS],
    output flit_t eject_flit [`ROUTER_PORTS],
    output logic eject_valid [`ROUTER_PORTS],
    switch_req_if.requester sw
);

    flit_t head [`ROUTER_PORTS];
    route_t route [`ROUTER_PORTS];
    logic [`ROUTER_PORTS-1:0] not_empty;
    logic [`ROUTER_PORTS-1:0] local_head;
    logic [`ROUTER_PORTS-1:0] pop;

    for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_port

        ////////////////////////////////////////////////////////////////////////////
        // input queue

        flit_queue flit_queue_i (
            .clk(clk),
            .reset(reset),
            .wr_flit(in_flit[p]),
            .wr_en(in_valid[p]),
            .rd_en(pop[p]),
            .head(head[p]),
            .not_empty(not_empty[p])
        );

        ////////////////////////////////////////////////////////////////////////////
        // route at queue head

        assign route[p] = route_of(head[p].dest, cur_x, cur_y, cur_z);
        assign local_head[p] = not_empty[p] && (route[p] == route_local);

        // local flits leave at once, others wait for a grant
        assign pop[p] = local_head[p] || sw.grant[p];

        assign sw.req_valid[p] = not_empty[p] && (route[p] != route_local);
        assign sw.req_flit[p] = head[p];
        assign sw.req_route[p] = route[p];

        ////////////////////////////////////////////////////////////////////////////
        // ejection to the kernel

        always_ff @(posedge clk) begin
            if (reset) begin
                eject_valid[p] <= 1'b0;
            end else begin
                eject_valid[p] <= local_head[p];
            end
        end

        always_ff @(posedge clk) begin
            if (local_head[p]) begin
                eject_flit[p] <= head[p];
            end
        end

        // the allocator must never take a flit that was already ejected
        assert property (@(posedge clk) disable iff (reset)
            local_head[p] |-> !sw.grant[p]);

    end

endmodule

//--- source/switch_alloc.sv
`timescale 1ns/100ps
`include "router_config.svh"

module switch_alloc import router_pkg::*; (
    input logic clk,
    input logic reset,
    switch_req_if.arbiter sw,
    input flit_t inject_flit [`ROUTER_PORTS],
    input logic inject_valid [`ROUTER_PORTS],
    output flit_t out_flit [`ROUTER_PORTS],
    output logic out_valid [`ROUTER_PORTS]
);

    // round-robin start point per output
    port_t rr_ptr [`ROUTER_PORTS];
    port_t winner [`ROUTER_PORTS];
    logic [`ROUTER_PORTS-1:0] win_valid;
    logic [`ROUTER_PORTS-1:0] grant_vec;
    // outputs that picked each input
    logic [`ROUTER_PORTS-1:0] grant_hits [`ROUTER_PORTS];

    ////////////////////////////////////////////////////////////////////////////
    // arbitration, one search per output

    always_comb begin
        int idx;
        for (int o = 0; o < `ROUTER_PORTS; o++) begin
            win_valid[o] = 1'b0;
            winner[o] = '0;
            for (int k = 0; k < `ROUTER_PORTS; k++) begin
                idx = int'(rr_ptr[o]) + k;
                if (idx >= `ROUTER_PORTS) begin
                    idx = idx - `ROUTER_PORTS;
                end
                // an injection owns the link this cycle
                if (!win_valid[o] && !inject_valid[o] && sw.req_valid[idx]
                        && (sw.req_route[idx] == route_t'(o))) begin
                    win_valid[o] = 1'b1;
                    winner[o] = port_t'(idx);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ROUTER_PORTS; i++) begin
            for (int o = 0; o < `ROUTER_PORTS; o++) begin
                grant_hits[i][o] = win_valid[o] && (winner[o] == port_t'(i));
            end
            grant_vec[i] = |grant_hits[i];
        end
    end

    for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_grant
        assign sw.grant[i] = grant_vec[i];

        // a waiting head must hold still until it is taken
        assert property (@(posedge clk) disable iff (reset)
            sw.req_valid[i] && !grant_vec[i] |=> sw.req_valid[i] && $stable(sw.req_flit[i]));

        // one head leaves by one output at most
        assert property (@(posedge clk) disable iff (reset) $onehot0(grant_hits[i]));
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointer update and output registers

    always_ff @(posedge clk) begin
        for (int o = 0; o < `ROUTER_PORTS; o++) begin
            if (reset) begin
                rr_ptr[o] <= '0;
                out_valid[o] <= 1'b0;
            end else begin
                out_valid[o] <= inject_valid[o] || win_valid[o];
                if (win_valid[o]) begin
                    // move just past the winner
                    rr_ptr[o] <= (winner[o] == port_t'(`ROUTER_PORTS - 1)) ?
                                 '0 : winner[o] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < `ROUTER_PORTS; o++) begin
            if (inject_valid[o]) begin
                out_flit[o] <= inject_flit[o];
            end else if (win_valid[o]) begin
                out_flit[o] <= sw.req_flit[winner[o]];
            end
        end
    end

endmodule

//--- source/torus_router.sv
`timescale 1ns/100ps
`include "router_config.svh"

module torus_router import router_pkg::*; #(
    parameter coord_t cur_x = '0,
    parameter coord_t cur_y = '0,
    parameter coord_t cur_z = '0
) (
    input logic clk,
    input logic reset,

    // neighbor links
    input flit_t in_flit [`ROUTER_PORTS],
    input logic in_valid [`ROUTER_PORTS],
    output flit_t out_flit [`ROUTER_PORTS],
    output logic out_valid [`ROUTER_PORTS],

    // kernel side
    input flit_t inject_flit [`ROUTER_PORTS],
    input logic inject_valid [`ROUTER_PORTS],
    output flit_t eject_flit [`ROUTER_PORTS],
    output logic eject_valid [`ROUTER_PORTS]
);

    switch_req_if switch_req_if_i ();

    ////////////////////////////////////////////////////////////////////////////
    // input queues, routing and ejection

    input_unit #(
        .cur_x(cur_x),
        .cur_y(cur_y),
        .cur_z(cur_z)
    ) input_unit_i (
        .clk(clk),
        .reset(reset),
        .in_flit(in_flit),
        .in_valid(in_valid),
        .eject_flit(eject_flit),
        .eject_valid(eject_valid),
        .sw(switch_req_if_i.requester)
    );

    ////////////////////////////////////////////////////////////////////////////
    // switch allocation and output links

    switch_alloc switch_alloc_i (
        .clk(clk),
        .reset(reset),
        .sw(switch_req_if_i.arbiter),
        .inject_flit(inject_flit),
        .inject_valid(inject_valid),
        .out_flit(out_flit),
        .out_valid(out_valid)
    );

endmodule

//--- dv/router_checker.sv
`timescale 1ns/100ps
`include "router_config.svh"

module router_checker import router_pkg::*; #(
    parameter coord_t cur_x = '0,
    parameter coord_t cur_y = '0,
    parameter coord_t cur_z = '0
) (
    input logic clk,
    input logic reset,
    input flit_t in_flit [`ROUTER_PORTS],
    input logic in_valid [`ROUTER_PORTS],
    input flit_t inject_flit [`ROUTER_PORTS],
    input logic inject_valid [`ROUTER_PORTS],
    input flit_t out_flit [`ROUTER_PORTS],
    input logic out_valid [`ROUTER_PORTS],
    input flit_t eject_flit [`ROUTER_PORTS],
    input logic eject_valid [`ROUTER_PORTS],
    input int test_id,
    input logic test_end,
    output int queue_level [`ROUTER_PORTS],
    output int failed_tests
);

    localparam int LAST_TEST = 5;
    localparam int LOCAL = 6;
    localparam int RING = 1 << `COORD_WIDTH;

    // flits in arrival order per input, until seen on a link or ejected
    flit_t model_q [`ROUTER_PORTS][$];
    flit_t expect_inject [`ROUTER_PORTS];
    logic expect_valid [`ROUTER_PORTS];
    int cur_test = 1;
    int test_errors = 0;
    int passed_tests = 0;

    // x first, then y, then z; later dimensions are overridden by earlier ones
    function automatic int expected_route(input dest_t dest);
        int own [3];
        int want [3];
        int d;
        int route;
        own = '{int'(cur_x), int'(cur_y), int'(cur_z)};
        want = '{int'(dest.x), int'(dest.y), int'(dest.z)};
        route = LOCAL;
        for (int k = 2; k >= 0; k--) begin
            d = (want[k] - own[k] + RING) % RING;
            if (d != 0) begin
                route = (d <= RING / 2) ? k : k + 3;
            end
        end
        return route;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset";
            2: return "injection";
            3: return "routing";
            4: return "ejection";
            default: return "mixed load";
        endcase
    endfunction

    task automatic report_mismatch(input string signal, input string want, input string got);
        $display("Fail %s expected %s got %s", signal, want, got);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        test_errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per-test report

    task automatic finish_test();
        int lost;
        lost = 0;
        if (cur_test == LAST_TEST) begin
            for (int p = 0; p < `ROUTER_PORTS; p++) begin
                lost += model_q[p].size();
            end
            if (lost > 0) begin
                report_problem($sformatf("%0d flits were lost inside the router", lost));
            end
        end
        if (test_errors == 0) begin
            passed_tests++;
            $display("test %0d %s: passed", cur_test, test_name(cur_test));
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", cur_test, test_name(cur_test),
                     test_errors);
        end
        test_errors = 0;
        if (cur_test == LAST_TEST) begin
            $display("tests passed %0d, tests failed %0d", passed_tests, failed_tests);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model update at the rising edge, comparison at the falling edge

    task automatic sample_inputs();
        if (test_end) begin
            finish_test();
        end
        cur_test = test_id;
        for (int p = 0; p < `ROUTER_PORTS; p++) begin
            expect_valid[p] = !reset && inject_valid[p];
            expect_inject[p] = inject_flit[p];
            if (reset) begin
                model_q[p].delete();
            end else if (in_valid[p]) begin
                model_q[p].push_back(in_flit[p]);
            end
            queue_level[p] = model_q[p].size();
        end
    endtask

    task automatic match_routed(input int o);
        bit found;
        flit_t head;
        found = 1'b0;
        for (int i = 0; i < `ROUTER_PORTS; i++) begin
            if (!found && model_q[i].size() > 0) begin
                head = model_q[i][0];
                if (expected_route(head.dest) == o && head == out_flit[o]) begin
                    void'(model_q[i].pop_front());
                    found = 1'b1;
                end
            end
        end
        if (!found) begin
            report_problem($sformatf(
                "out_flit[%0d] carried %h, the oldest flit of no input routed there",
                o, out_flit[o]));
        end
    endtask

    task automatic check_eject(input int p);
        flit_t head;
        if (model_q[p].size() == 0) begin
            report_problem($sformatf("eject_valid[%0d] rose while input %0d held no flit", p, p));
        end else begin
            head = model_q[p].pop_front();
            if (eject_flit[p] !== head) begin
                report_mismatch($sformatf("eject_flit[%0d]", p), $sformatf("%h", head),
                                $sformatf("%h", eject_flit[p]));
            end else if (expected_route(head.dest) != LOCAL) begin
                report_problem($sformatf("eject_flit[%0d] carried %h, which belongs on link %0d",
                                         p, head, expected_route(head.dest)));
            end
        end
    endtask

    task automatic check_outputs();
        for (int p = 0; p < `ROUTER_PORTS; p++) begin
            if (cur_test == 1) begin
                if (out_valid[p] !== 1'b0) begin
                    report_mismatch($sformatf("out_valid[%0d]", p), "0",
                                    $sformatf("%h", out_valid[p]));
                end
                if (eject_valid[p] !== 1'b0) begin
                    report_mismatch($sformatf("eject_valid[%0d]", p), "0",
                                    $sformatf("%h", eject_valid[p]));
                end
            end
            if (expect_valid[p]) begin
                if (out_valid[p] !== 1'b1) begin
                    report_mismatch($sformatf("out_valid[%0d]", p), "1",
                                    $sformatf("%h", out_valid[p]));
                end else if (out_flit[p] !== expect_inject[p]) begin
                    report_mismatch($sformatf("out_flit[%0d]", p), $sformatf("%h", expect_inject[p]),
                                    $sformatf("%h", out_flit[p]));
                end
            end else if (out_valid[p] === 1'b1) begin
                match_routed(p);
            end
            if (eject_valid[p] === 1'b1) begin
                check_eject(p);
            end
        end
    endtask

    initial begin
        failed_tests = 0;
        for (int p = 0; p < `ROUTER_PORTS; p++) begin
            queue_level[p] = 0;
            expect_valid[p] = 1'b0;
        end
        forever begin
            @(posedge clk);
            sample_inputs();
            @(negedge clk);
            check_outputs();
        end
    end

endmodule

//--- dv/router_tb.sv
`timescale 1ns/100ps
`include "router_config.svh"

module router_tb import router_pkg::*; ();

    localparam coord_t NODE_X = 3'd2;
    localparam coord_t NODE_Y = 3'd5;
    localparam coord_t NODE_Z = 3'd7;

    logic clk = 1'b0;
    logic reset;
    flit_t in_flit [`ROUTER_PORTS];
    logic in_valid [`ROUTER_PORTS];
    flit_t out_flit [`ROUTER_PORTS];
    logic out_valid [`ROUTER_PORTS];
    flit_t inject_flit [`ROUTER_PORTS];
    logic inject_valid [`ROUTER_PORTS];
    flit_t eject_flit [`ROUTER_PORTS];
    logic eject_valid [`ROUTER_PORTS];

    int test_id;
    logic test_end;
    int queue_level [`ROUTER_PORTS];
    int failed_tests;
    int flits_sent = 0;
    int seq = 0;
    int cycle_count = 0;

    torus_router #(
        .cur_x(NODE_X),
        .cur_y(NODE_Y),
        .cur_z(NODE_Z)
    ) torus_router_i (
        .clk(clk),
        .reset(reset),
        .in_flit(in_flit),
        .in_valid(in_valid),
        .out_flit(out_flit),
        .out_valid(out_valid),
        .inject_flit(inject_flit),
        .inject_valid(inject_valid),
        .eject_flit(eject_flit),
        .eject_valid(eject_valid)
    );

    router_checker #(
        .cur_x(NODE_X),
        .cur_y(NODE_Y),
        .cur_z(NODE_Z)
    ) router_checker_i (
        .clk(clk),
        .reset(reset),
        .in_flit(in_flit),
        .in_valid(in_valid),
        .inject_flit(inject_flit),
        .inject_valid(inject_valid),
        .out_flit(out_flit),
        .out_valid(out_valid),
        .eject_flit(eject_flit),
        .eject_valid(eject_valid),
        .test_id(test_id),
        .test_end(test_end),
        .queue_level(queue_level),
        .failed_tests(failed_tests)
    );

    always #50 clk = ~clk;

    // 20 cycles per flit on top of a fixed allowance
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 20 * flits_sent + 200) begin
            $display("timeout at cycle %0d after %0d flits sent", cycle_count, flits_sent);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    // mode 1 sends a quarter to this node, mode 2 sends all of them here
    function automatic flit_t make_flit(input int local_mode, input int tag_seq);
        flit_t f;
        f.dest.x = coord_t'($urandom % 8);
        f.dest.y = coord_t'($urandom % 8);
        f.dest.z = coord_t'($urandom % 8);
        if (local_mode == 2 || (local_mode == 1 && $urandom % 4 == 0)) begin
            f.dest = {NODE_Z, NODE_Y, NODE_X};
        end
        f.tag = tag_t'(tag_seq);
        f.payload = $urandom;
        return f;
    endfunction

    task automatic drive_cycle(input bit links_on, input int local_mode, input bit inject_on);
        bit send;
        bit inj;
        @(negedge clk);
        for (int p = 0; p < `ROUTER_PORTS; p++) begin
            send = links_on && ($urandom % 4 == 0);
            inj = inject_on && ($urandom % 8 == 0);
            // headroom for flits still on their way out
            in_valid[p] = send && (queue_level[p] < `QUEUE_DEPTH - 4);
            inject_valid[p] = inj;
            if (in_valid[p]) begin
                in_flit[p] = make_flit(local_mode, seq);
                seq++;
                flits_sent++;
            end
            if (inj) begin
                inject_flit[p] = make_flit(0, seq);
                seq++;
                flits_sent++;
            end
        end
    endtask

    task automatic end_test();
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    task automatic run_phase(input int id, input int busy, input bit links_on,
                             input int local_mode, input bit inject_on, input int idle);
        test_id = id;
        repeat (busy) drive_cycle(links_on, local_mode, inject_on);
        repeat (idle) drive_cycle(1'b0, 0, 1'b0);
        end_test();
    endtask

    initial begin
        void'($urandom(84));
        reset = 1'b1;
        test_id = 1;
        test_end = 1'b0;
        for (int p = 0; p < `ROUTER_PORTS; p++) begin
            in_flit[p] = '0;
            in_valid[p] = 1'b0;
            inject_flit[p] = '0;
            inject_valid[p] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // first cycle out of reset still belongs to test 1
        end_test();
        run_phase(2, 200, 1'b0, 0, 1'b1, 5);
        run_phase(3, 300, 1'b1, 0, 1'b0, 50);
        run_phase(4, 300, 1'b1, 2, 1'b0, 50);
        run_phase(5, 400, 1'b1, 1, 1'b1, 200);
        if (failed_tests == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/router_pkg.sv
source/switch_req_if.sv
source/flit_queue.sv
source/input_unit.sv
source/switch_alloc.sv
source/torus_router.sv
dv/router_checker.sv
dv/router_tb.sv

//--- Makefile
TOP = router_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
